//--- verilog/game_config.svh
`ifndef GAME_CONFIG_SVH
`define GAME_CONFIG_SVH

// maze size in cells
`define MAZE_W 40
`define MAZE_H 30

// sprite start cells
`define PAC_START_X 1
`define PAC_START_Y 1
`define GHOST1_START_X 38
`define GHOST1_START_Y 28
`define GHOST2_START_X 38
`define GHOST2_START_Y 1

`define START_LIVES 3
`define DOTS_TO_WIN 20

// board timing at 50 MHz: pac every 0.1 s, ghosts every 0.15 s, 5 s pause
`define PAC_STEP_DEFAULT 5000000
`define GHOST_STEP_DEFAULT 7500000
`define RESUME_DEFAULT 250000000

`endif

//--- verilog/maze_pkg.sv
`default_nettype none

package maze_pkg;

	// column index, 0 to 39
	typedef logic [5:0] cell_x_t;

	// row index, 0 to 29
	typedef logic [4:0] cell_y_t;

	// what a maze cell holds
	typedef enum logic [1:0] {
		tile_empty = 2'd0,
		tile_wall  = 2'd1,
		tile_pill  = 2'd2
	} tile_t;

	// pac-man heading
	typedef enum logic [1:0] {
		dir_up    = 2'd0,
		dir_down  = 2'd1,
		dir_left  = 2'd2,
		dir_right = 2'd3
	} dir_t;

endpackage

`default_nettype wire

//--- verilog/game_pkg.sv
`default_nettype none

package game_pkg;

	// top-level game flow
	typedef enum logic [2:0] {
		st_init   = 3'd0,
		st_play   = 3'd1,
		st_resume = 3'd2,
		st_over   = 3'd3,
		st_win    = 3'd4
	} game_state_t;

	// remaining lives, shown on one hex digit
	typedef logic [2:0] lives_t;

endpackage

`default_nettype wire

//--- verilog/maze_tiles.sv
`timescale 1ns/1ns
`include "game_config.svh"
`default_nettype none

module maze_tiles (
	input logic CLOCK_50,
	input logic game_reset,
	input maze_pkg::cell_x_t rd_x,
	input maze_pkg::cell_y_t rd_y,
	output maze_pkg::tile_t tile,
	input logic clr_en,
	input maze_pkg::cell_x_t clr_x,
	input maze_pkg::cell_y_t clr_y,
	output logic ready
);
	import maze_pkg::*;

	// one word per row, two bits per cell
	logic [2*`MAZE_W-1:0] mem [`MAZE_H];
	logic [2*`MAZE_W-1:0] rd_word;
	logic [2*`MAZE_W-1:0] fill_word;
	cell_x_t rd_x_q;
	cell_y_t fill_row;
	logic filling;

	assign filling = !game_reset && !ready;

	// border is wall, interior starts with a pill
	always_comb begin
		for (int c = 0; c < `MAZE_W; c++) begin
			if (fill_row == 5'd0 || fill_row == 5'(`MAZE_H - 1) || c == 0 || c == `MAZE_W - 1)
				fill_word[2*c +: 2] = tile_wall;
			else
				fill_word[2*c +: 2] = tile_pill;
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (game_reset) begin
			fill_row <= '0;
			ready <= 1'b0;
		end else if (!ready) begin
			if (fill_row == 5'(`MAZE_H - 1))
				ready <= 1'b1;
			else
				fill_row <= fill_row + 5'd1;
		end
	end

	// the mover only clears cells it has just read as a pill
	always_ff @(posedge CLOCK_50) begin
		if (filling)
			mem[fill_row] <= fill_word;
		else if (clr_en)
			mem[clr_y][clr_x*2 +: 2] <= tile_empty;
		rd_word <= mem[rd_y];
		rd_x_q <= rd_x;
	end

	assign tile = tile_t'(rd_word[rd_x_q*2 +: 2]);

endmodule

`default_nettype wire

//--- verilog/pacman_mover.sv
`timescale 1ns/1ns
`include "game_config.svh"
`default_nettype none

module pacman_mover #(
	parameter int STEP_CYCLES = `PAC_STEP_DEFAULT
) (
	input logic CLOCK_50,
	input logic sprite_reset,
	input logic btn_up,
	input logic btn_down,
	input logic btn_left,
	input logic btn_right,
	input maze_pkg::tile_t tile,
	output maze_pkg::cell_x_t rd_x,
	output maze_pkg::cell_y_t rd_y,
	output logic clr_en,
	output maze_pkg::cell_x_t clr_x,
	output maze_pkg::cell_y_t clr_y,
	output logic pill_eaten,
	output maze_pkg::cell_x_t pac_x,
	output maze_pkg::cell_y_t pac_y
);
	import maze_pkg::*;

	localparam int CNT_W = $clog2(STEP_CYCLES + 1);

	dir_t heading;
	logic [CNT_W-1:0] step_cnt;
	logic tick;
	logic pending;
	logic step_ok;
	cell_x_t tgt_x;
	cell_y_t tgt_y;

	assign tick = !sprite_reset && (step_cnt == CNT_W'(STEP_CYCLES - 1));

	// cell ahead in the current heading, read on the tick
	always_comb begin
		rd_x = pac_x;
		rd_y = pac_y;
		case (heading)
			dir_up: rd_y = pac_y - 5'd1;
			dir_down: rd_y = pac_y + 5'd1;
			dir_left: rd_x = pac_x - 6'd1;
			default: rd_x = pac_x + 6'd1;
		endcase
	end

	// tile is valid the cycle after the tick
	assign step_ok = pending && !sprite_reset && (tile != tile_wall);
	assign pill_eaten = step_ok && (tile == tile_pill);
	assign clr_en = pill_eaten;
	assign clr_x = tgt_x;
	assign clr_y = tgt_y;

	// up wins over down, down over left, left over right
	always_ff @(posedge CLOCK_50) begin
		if (sprite_reset)
			heading <= dir_right;
		else if (btn_up)
			heading <= dir_up;
		else if (btn_down)
			heading <= dir_down;
		else if (btn_left)
			heading <= dir_left;
		else if (btn_right)
			heading <= dir_right;
	end

	always_ff @(posedge CLOCK_50) begin
		if (sprite_reset) begin
			step_cnt <= '0;
			pending <= 1'b0;
			pac_x <= 6'(`PAC_START_X);
			pac_y <= 5'(`PAC_START_Y);
		end else begin
			if (tick)
				step_cnt <= '0;
			else
				step_cnt <= step_cnt + 1'b1;
			pending <= tick;
			if (step_ok) begin
				pac_x <= tgt_x;
				pac_y <= tgt_y;
			end
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (tick) begin
			tgt_x <= rd_x;
			tgt_y <= rd_y;
		end
	end

endmodule

`default_nettype wire

//--- verilog/ghost_chaser.sv
`timescale 1ns/1ns
`include "game_config.svh"
`default_nettype none

module ghost_chaser #(
	parameter int STEP_CYCLES = `GHOST_STEP_DEFAULT,
	parameter maze_pkg::cell_x_t START_X = 6'(`GHOST1_START_X),
	parameter maze_pkg::cell_y_t START_Y = 5'(`GHOST1_START_Y)
) (
	input logic CLOCK_50,
	input logic sprite_reset,
	input logic ghost_enable,
	input maze_pkg::cell_x_t pac_x,
	input maze_pkg::cell_y_t pac_y,
	output maze_pkg::cell_x_t ghost_x,
	output maze_pkg::cell_y_t ghost_y
);
	import maze_pkg::*;

	localparam int CNT_W = $clog2(STEP_CYCLES + 1);

	logic [CNT_W-1:0] step_cnt;
	logic tick;

	assign tick = ghost_enable && (step_cnt == CNT_W'(STEP_CYCLES - 1));

	// timer only runs while the game is in play
	always_ff @(posedge CLOCK_50) begin
		if (sprite_reset) begin
			step_cnt <= '0;
			ghost_x <= START_X;
			ghost_y <= START_Y;
		end else if (ghost_enable) begin
			if (tick)
				step_cnt <= '0;
			else
				step_cnt <= step_cnt + 1'b1;
			if (tick) begin
				// column gap first, then row gap
				if (ghost_x < pac_x)
					ghost_x <= ghost_x + 6'd1;
				else if (ghost_x > pac_x)
					ghost_x <= ghost_x - 6'd1;
				else if (ghost_y < pac_y)
					ghost_y <= ghost_y + 5'd1;
				else if (ghost_y > pac_y)
					ghost_y <= ghost_y - 5'd1;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/game_fsm.sv
`timescale 1ns/1ns
`include "game_config.svh"
`default_nettype none

module game_fsm #(
	parameter int RESUME_CYCLES = `RESUME_DEFAULT
) (
	input logic CLOCK_50,
	input logic game_reset,
	input logic start,
	input logic maze_ready,
	input maze_pkg::cell_x_t pac_x,
	input maze_pkg::cell_y_t pac_y,
	input maze_pkg::cell_x_t g1_x,
	input maze_pkg::cell_y_t g1_y,
	input maze_pkg::cell_x_t g2_x,
	input maze_pkg::cell_y_t g2_y,
	input logic [9:0] score,
	output game_pkg::game_state_t state,
	output game_pkg::lives_t lives,
	output logic sprite_reset,
	output logic ghost_enable
);
	import maze_pkg::*;
	import game_pkg::*;

	localparam int CNT_W = $clog2(RESUME_CYCLES + 1);

	logic [CNT_W-1:0] resume_cnt;
	logic catch_g1;
	logic catch_g2;
	logic caught;

	assign catch_g1 = (g1_x == pac_x) && (g1_y == pac_y);
	assign catch_g2 = (g2_x == pac_x) && (g2_y == pac_y);
	assign caught = catch_g1 || catch_g2;

	// sprites only move in play
	assign sprite_reset = (state != st_play);
	assign ghost_enable = (state == st_play);

	always_ff @(posedge CLOCK_50) begin
		if (game_reset) begin
			state <= st_init;
			lives <= 3'(`START_LIVES);
			resume_cnt <= '0;
		end else begin
			case (state)
				st_init: begin
					// wait for the maze refill before starting
					if (start && maze_ready)
						state <= st_play;
				end
				st_play: begin
					if (caught) begin
						if (lives > 3'd1) begin
							lives <= lives - 3'd1;
							state <= st_resume;
						end else begin
							lives <= 3'd0;
							state <= st_over;
						end
					end else if (score >= 10'(`DOTS_TO_WIN)) begin
						state <= st_win;
					end
				end
				st_resume: begin
					if (resume_cnt == CNT_W'(RESUME_CYCLES - 1)) begin
						resume_cnt <= '0;
						state <= st_play;
					end else begin
						resume_cnt <= resume_cnt + 1'b1;
					end
				end
				// over and win wait for game_reset
				default: state <= state;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/score_display.sv
`timescale 1ns/1ns
`default_nettype none

module score_display (
	input logic CLOCK_50,
	input logic sprite_hold,
	input logic game_reset,
	input logic pill_eaten,
	input game_pkg::lives_t lives,
	output logic [9:0] score,
	output logic [6:0] hex0,
	output logic [6:0] hex1,
	output logic [6:0] hex2,
	output logic [6:0] hex3,
	output logic [6:0] hex4,
	output logic [6:0] hex5
);
	import game_pkg::*;

	logic [3:0] ones;
	logic [3:0] tens;
	logic [3:0] hundreds;

	// active-low segments, gfedcba
	function automatic logic [6:0] seg7(input logic [3:0] d);
		case (d)
			4'd0: seg7 = 7'b1000000;
			4'd1: seg7 = 7'b1111001;
			4'd2: seg7 = 7'b0100100;
			4'd3: seg7 = 7'b0110000;
			4'd4: seg7 = 7'b0011001;
			4'd5: seg7 = 7'b0010010;
			4'd6: seg7 = 7'b0000010;
			4'd7: seg7 = 7'b1111000;
			4'd8: seg7 = 7'b0000000;
			4'd9: seg7 = 7'b0010000;
			default: seg7 = 7'b1111111;
		endcase
	endfunction

	// decimal counter, wraps after 999
	always_ff @(posedge CLOCK_50) begin
		if (game_reset) begin
			ones <= 4'd0;
			tens <= 4'd0;
			hundreds <= 4'd0;
		end else if (pill_eaten && !sprite_hold) begin
			if (ones != 4'd9) begin
				ones <= ones + 4'd1;
			end else begin
				ones <= 4'd0;
				if (tens != 4'd9) begin
					tens <= tens + 4'd1;
				end else begin
					tens <= 4'd0;
					hundreds <= (hundreds == 4'd9) ? 4'd0 : hundreds + 4'd1;
				end
			end
		end
	end

	assign score = 10'(hundreds) * 10'd100 + 10'(tens) * 10'd10 + 10'(ones);

	assign hex5 = seg7(hundreds);
	assign hex4 = seg7(tens);
	assign hex3 = seg7(ones);
	assign hex2 = 7'b1111111;
	assign hex1 = 7'b1111111;
	assign hex0 = seg7({1'b0, lives});

endmodule

`default_nettype wire

//--- verilog/pacman_top.sv
`timescale 1ns/1ns
`include "game_config.svh"
`default_nettype none

module pacman_top #(
	parameter int PAC_STEP = `PAC_STEP_DEFAULT,
	parameter int GHOST_STEP = `GHOST_STEP_DEFAULT,
	parameter int RESUME = `RESUME_DEFAULT
) (
	input logic CLOCK_50,
	input logic game_reset,
	input logic btn_up,
	input logic btn_down,
	input logic btn_left,
	input logic btn_right,
	input logic start,
	output logic [6:0] hex0,
	output logic [6:0] hex1,
	output logic [6:0] hex2,
	output logic [6:0] hex3,
	output logic [6:0] hex4,
	output logic [6:0] hex5,
	output game_pkg::game_state_t state,
	output game_pkg::lives_t lives,
	output logic [9:0] score,
	output maze_pkg::cell_x_t pac_x,
	output maze_pkg::cell_y_t pac_y
);
	import maze_pkg::*;
	import game_pkg::*;

	cell_x_t rd_x, clr_x, g1_x, g2_x;
	cell_y_t rd_y, clr_y, g1_y, g2_y;
	tile_t tile;
	logic clr_en, pill_eaten, maze_ready;
	logic sprite_reset, ghost_enable;

	maze_tiles maze0 (.CLOCK_50(CLOCK_50), .game_reset(game_reset),
		.rd_x(rd_x), .rd_y(rd_y), .tile(tile),
		.clr_en(clr_en), .clr_x(clr_x), .clr_y(clr_y), .ready(maze_ready));

	pacman_mover #(.STEP_CYCLES(PAC_STEP)) pac0 (.CLOCK_50(CLOCK_50),
		.sprite_reset(sprite_reset), .btn_up(btn_up), .btn_down(btn_down),
		.btn_left(btn_left), .btn_right(btn_right), .tile(tile), .rd_x(rd_x), .rd_y(rd_y),
		.clr_en(clr_en), .clr_x(clr_x), .clr_y(clr_y), .pill_eaten(pill_eaten),
		.pac_x(pac_x), .pac_y(pac_y));

	// two ghosts, same chaser with different start cells
	ghost_chaser #(.STEP_CYCLES(GHOST_STEP), .START_X(cell_x_t'(`GHOST1_START_X)),
		.START_Y(cell_y_t'(`GHOST1_START_Y))) ghost1 (.CLOCK_50(CLOCK_50),
		.sprite_reset(sprite_reset), .ghost_enable(ghost_enable),
		.pac_x(pac_x), .pac_y(pac_y), .ghost_x(g1_x), .ghost_y(g1_y));

	ghost_chaser #(.STEP_CYCLES(GHOST_STEP), .START_X(cell_x_t'(`GHOST2_START_X)),
		.START_Y(cell_y_t'(`GHOST2_START_Y))) ghost2 (.CLOCK_50(CLOCK_50),
		.sprite_reset(sprite_reset), .ghost_enable(ghost_enable),
		.pac_x(pac_x), .pac_y(pac_y), .ghost_x(g2_x), .ghost_y(g2_y));

	game_fsm #(.RESUME_CYCLES(RESUME)) fsm0 (.CLOCK_50(CLOCK_50), .game_reset(game_reset),
		.start(start), .maze_ready(maze_ready), .pac_x(pac_x), .pac_y(pac_y),
		.g1_x(g1_x), .g1_y(g1_y), .g2_x(g2_x), .g2_y(g2_y), .score(score),
		.state(state), .lives(lives), .sprite_reset(sprite_reset),
		.ghost_enable(ghost_enable));

	score_display score0 (.CLOCK_50(CLOCK_50), .sprite_hold(sprite_reset),
		.game_reset(game_reset), .pill_eaten(pill_eaten), .lives(lives), .score(score),
		.hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3), .hex4(hex4), .hex5(hex5));

endmodule

`default_nettype wire

//--- verif/pacman_props.sv
`timescale 1ns/1ns
`default_nettype none

module game_fsm_props (
	input logic CLOCK_50,
	input logic game_reset,
	input game_pkg::game_state_t state,
	input game_pkg::lives_t lives,
	input logic ghost_enable
);
	import game_pkg::*;

	// lives only go down within one game
	lives_no_rise: assert property (@(posedge CLOCK_50) disable iff (game_reset)
		1'b1 |=> lives <= $past(lives))
	else $error("lives went up without a reset");

	// each catch costs exactly one life
	lives_drop_on_catch: assert property (@(posedge CLOCK_50) disable iff (game_reset)
		$changed(state) && (state == st_resume || state == st_over)
		|-> lives == $past(lives) - 3'd1)
	else $error("lives did not drop by one on a catch");

	end_states_hold: assert property (@(posedge CLOCK_50) disable iff (game_reset)
		(state == st_over || state == st_win) |=> state == $past(state))
	else $error("over or win left without a reset");

	// ghosts only run in play
	ghost_only_in_play: assert property (@(posedge CLOCK_50) disable iff (game_reset)
		state != st_play |-> !ghost_enable)
	else $error("ghost_enable high outside play");

endmodule

bind game_fsm game_fsm_props props0 (
	.CLOCK_50(CLOCK_50),
	.game_reset(game_reset),
	.state(state),
	.lives(lives),
	.ghost_enable(ghost_enable)
);

`default_nettype wire

//--- verif/pacman_tb.sv
`timescale 1ns/1ns
`include "game_config.svh"
`default_nettype none

module pacman_tb;
	import maze_pkg::*;
	import game_pkg::*;

	localparam int PAC_STEP = 4;
	localparam int GHOST_STEP = 12;
	localparam int RESUME = 16;
	localparam int MAX_CYCLES = 20000;
	localparam int WALK_LIMIT = 60;

	logic CLOCK_50;
	logic game_reset;
	logic btn_up;
	logic btn_down;
	logic btn_left;
	logic btn_right;
	logic start;
	logic [6:0] hex0;
	logic [6:0] hex1;
	logic [6:0] hex2;
	logic [6:0] hex3;
	logic [6:0] hex4;
	logic [6:0] hex5;
	game_state_t state;
	lives_t lives;
	logic [9:0] score;
	cell_x_t pac_x;
	cell_y_t pac_y;

	// reference model: pill map, pac-man cell, score and lives
	bit pill_map [`MAZE_H][`MAZE_W];
	int exp_x;
	int exp_y;
	int exp_score;
	int exp_lives;
	bit row_locked;
	int cycles = 0;

	pacman_top #(.PAC_STEP(PAC_STEP), .GHOST_STEP(GHOST_STEP), .RESUME(RESUME)) dut0 (
		.CLOCK_50(CLOCK_50), .game_reset(game_reset),
		.btn_up(btn_up), .btn_down(btn_down), .btn_left(btn_left), .btn_right(btn_right),
		.start(start), .hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3), .hex4(hex4),
		.hex5(hex5), .state(state), .lives(lives), .score(score),
		.pac_x(pac_x), .pac_y(pac_y));

	always #50 CLOCK_50 = ~CLOCK_50;

	always @(posedge CLOCK_50) begin
		cycles++;
		if (cycles == MAX_CYCLES) begin
			$display("Timeout: the game did not finish within %0d cycles", MAX_CYCLES);
			$display("Some tests failed");
			$fatal(1, "cycle limit reached");
		end
	end

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Some tests failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic expect_value(input string name, input int expected, input int actual);
		assert (expected == actual)
		else stop_on_error($sformatf("FAILED %s: expected %0d, got %0d", name, expected, actual));
	endtask

	// lit segments gfedcba, the board drives them low
	function automatic logic [6:0] digit_segments(input int d);
		logic [6:0] lit;
		case (d)
			0: lit = 7'h3f;
			1: lit = 7'h06;
			2: lit = 7'h5b;
			3: lit = 7'h4f;
			4: lit = 7'h66;
			5: lit = 7'h6d;
			6: lit = 7'h7d;
			7: lit = 7'h07;
			8: lit = 7'h7f;
			9: lit = 7'h6f;
			default: lit = 7'h00;
		endcase
		return ~lit;
	endfunction

	function automatic bit is_border(input int x, input int y);
		return x == 0 || y == 0 || x == `MAZE_W - 1 || y == `MAZE_H - 1;
	endfunction

	task automatic check_display(input string name);
		expect_value({name, " score"}, exp_score, score);
		expect_value({name, " hex5"}, digit_segments(exp_score / 100), hex5);
		expect_value({name, " hex4"}, digit_segments((exp_score / 10) % 10), hex4);
		expect_value({name, " hex3"}, digit_segments(exp_score % 10), hex3);
		expect_value({name, " lives"}, exp_lives, lives);
		expect_value({name, " hex0"}, digit_segments(exp_lives), hex0);
	endtask

	task automatic hold_buttons(input dir_t dir);
		btn_up = (dir == dir_up);
		btn_down = (dir == dir_down);
		btn_left = (dir == dir_left);
		btn_right = (dir == dir_right);
	endtask

	task automatic reset_game();
		game_reset = 1'b1;
		start = 1'b0;
		btn_up = 1'b0;
		btn_down = 1'b0;
		btn_left = 1'b0;
		btn_right = 1'b0;
		repeat (5) @(posedge CLOCK_50);
		#1;
		game_reset = 1'b0;
		for (int y = 0; y < `MAZE_H; y++)
			for (int x = 0; x < `MAZE_W; x++)
				pill_map[y][x] = !is_border(x, y);
		exp_x = `PAC_START_X;
		exp_y = `PAC_START_Y;
		exp_score = 0;
		exp_lives = `START_LIVES;
	endtask

	// checks the reset values, then starts and waits out the maze refill
	task automatic start_game(input string name);
		int waited;
		waited = 0;
		expect_value({name, " state"}, st_init, state);
		check_display(name);
		start = 1'b1;
		while (state != st_play) begin
			@(posedge CLOCK_50);
			#1;
			waited++;
		end
		expect_value({name, " refill wait"}, `MAZE_H + 1, waited);
		// step ticks then land every PAC_STEP cycles from here
		@(posedge CLOCK_50);
		#1;
	endtask

	task automatic take_step(input string name, input dir_t dir);
		int nx;
		int ny;
		hold_buttons(dir);
		nx = exp_x;
		ny = exp_y;
		case (dir)
			dir_up: ny--;
			dir_down: ny++;
			dir_left: nx--;
			default: nx++;
		endcase
		if (!is_border(nx, ny)) begin
			exp_x = nx;
			exp_y = ny;
			if (pill_map[ny][nx]) begin
				pill_map[ny][nx] = 1'b0;
				exp_score++;
			end
		end
		repeat (PAC_STEP) @(posedge CLOCK_50);
		#1;
		expect_value({name, " pac_x"}, exp_x, pac_x);
		expect_value({name, " pac_y"}, exp_y, pac_y);
		check_display(name);
	endtask

	// walking along the top row never changes the row
	assert property (@(posedge CLOCK_50) row_locked |-> pac_y == cell_y_t'(`PAC_START_Y))
	else stop_on_error($sformatf("FAILED row walk pac_y: expected %0d, got %0d",
		`PAC_START_Y, pac_y));

	assert property (@(posedge CLOCK_50) disable iff (game_reset)
		hex1 == 7'h7f && hex2 == 7'h7f)
	else stop_on_error($sformatf("FAILED blank digits: expected 7f 7f, got %h %h", hex2, hex1));

	initial begin
		int waited;
		int steps;
		game_state_t final_state;
		CLOCK_50 = 1'b0;
		row_locked = 1'b0;
		void'($urandom(32'hc8de));
		reset_game();
		start_game("reset values");

		// right into fresh pills, back over eaten cells, then against the left wall
		row_locked = 1'b1;
		repeat (5) take_step("walk right", dir_right);
		repeat (8) take_step("walk left", dir_left);
		row_locked = 1'b0;

		// park off the start cell and let the ghosts come
		repeat (2) take_step("walk down", dir_down);
		hold_buttons(dir_left);
		for (int n = 0; n < `START_LIVES; n++) begin
			while (state == st_play) begin
				@(posedge CLOCK_50);
				#1;
			end
			exp_lives--;
			if (exp_lives > 0) begin
				expect_value("catch state", st_resume, state);
				check_display("catch");
				waited = 0;
				while (state == st_resume) begin
					@(posedge CLOCK_50);
					#1;
					waited++;
				end
				expect_value("resume length", RESUME, waited);
				expect_value("resume state", st_play, state);
				exp_x = `PAC_START_X;
				exp_y = `PAC_START_Y;
				expect_value("resume pac_x", exp_x, pac_x);
				expect_value("resume pac_y", exp_y, pac_y);
				check_display("resume");
			end else begin
				expect_value("game over state", st_over, state);
				check_display("game over");
			end
		end
		repeat (4) @(posedge CLOCK_50);
		#1;
		expect_value("over held", st_over, state);

		// only down or right, so every step lands on a fresh pill far from the ghosts
		reset_game();
		start_game("second run");
		steps = 0;
		while (exp_score < `DOTS_TO_WIN && steps < WALK_LIMIT) begin
			if (($urandom % 2) == 0)
				take_step("random walk", dir_down);
			else
				take_step("random walk", dir_right);
			steps++;
		end
		@(posedge CLOCK_50);
		#1;
		final_state = (exp_score >= `DOTS_TO_WIN) ? st_win : st_play;
		expect_value("final state", final_state, state);
		repeat (4) @(posedge CLOCK_50);
		#1;
		expect_value("final state held", final_state, state);

		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+verilog
verilog/maze_pkg.sv
verilog/game_pkg.sv
verilog/maze_tiles.sv
verilog/pacman_mover.sv
verilog/ghost_chaser.sv
verilog/game_fsm.sv
verilog/score_display.sv
verilog/pacman_top.sv
verif/pacman_props.sv
verif/pacman_tb.sv

//--- Bender.yml
package:
  name: pacman_game

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/maze_pkg.sv
      - verilog/game_pkg.sv
      - verilog/maze_tiles.sv
      - verilog/pacman_mover.sv
      - verilog/ghost_chaser.sv
      - verilog/game_fsm.sv
      - verilog/score_display.sv
      - verilog/pacman_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/pacman_props.sv
      - verif/pacman_tb.sv
